// ==== project.f ====
rtl/tia_pkg.sv
rtl/channel_fifo.sv
rtl/host_port.sv
rtl/trigger_unit.sv
rtl/integer_alu.sv
rtl/execute_stage.sv
rtl/tia_core.sv
sim/core_checker.sv
sim/tb_top.sv

// ==== rtl/channel_fifo.sv ====
`default_nettype none

module channel_fifo
    import tia_pkg::*;
#(
    parameter int depth = chan_depth
) (
    input wire logic clock,
    input wire logic rst,
    input wire logic push,
    input wire packet_t push_packet,
    input wire logic pop,
    output packet_t head,
    output logic empty,
    output logic full
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    packet_t mem [depth];
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [count_width-1:0] count;

    assign head = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == count_width'(depth));

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_packet;
        end
    end

    // Pointers wrap at depth, which need not be a power of two.
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + count_width'(push) - count_width'(pop);
        end
    end

    push_not_full: assert property (@(posedge clock) disable iff (rst) push |-> !full);
    pop_not_empty: assert property (@(posedge clock) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage
    import tia_pkg::*;
(
    input wire logic clock,
    input wire logic rst,
    input wire logic fire,
    input wire instr_t fire_instr,
    input wire packet_t in_heads [num_in],
    output instr_t x_instr,
    output logic [num_in-1:0] pop,
    output logic [num_out-1:0] push,
    output packet_t push_packet,
    output logic pred_we,
    output logic [reg_index_width-1:0] pred_idx,
    output logic pred_val,
    output logic [word_width-1:0] regs [num_regs],
    output logic halted
);

    logic [word_width-1:0] operand_a;
    logic [word_width-1:0] operand_b;
    logic [word_width-1:0] result;

    function automatic logic [word_width-1:0] fetch(
        input src_t st,
        input logic [reg_index_width-1:0] si,
        input logic [word_width-1:0] imm
    );
        logic [word_width-1:0] value;
        case (st)
            src_imm: value = imm;
            src_reg: value = regs[si];
            src_chan: value = in_heads[si[$clog2(num_in)-1:0]].data;
            default: value = '0;
        endcase
        return value;
    endfunction

    // T|X pipeline register, a bubble when nothing fires.
    always_ff @(posedge clock) begin
        if (rst) begin
            x_instr <= '0;
        end else begin
            x_instr <= fire ? fire_instr : '0;
        end
    end

    assign operand_a = fetch(x_instr.st0, x_instr.si0, x_instr.imm);
    assign operand_b = fetch(x_instr.st1, x_instr.si1, x_instr.imm);

    integer_alu u_alu (
        .op(x_instr.op),
        .a(operand_a),
        .b(operand_b),
        .result(result)
    );

    // Destination routing.
    always_comb begin
        pred_we = 1'b0;
        push = '0;
        case (x_instr.dt)
            dst_pred: pred_we = x_instr.vi;
            dst_out: begin
                for (int c = 0; c < num_out; c++) begin
                    push[c] = x_instr.vi && (x_instr.di == c);
                end
            end
            dst_reg, dst_none: begin
            end
            default: begin
            end
        endcase
    end

    assign pred_idx = x_instr.di;
    assign pred_val = result[0];
    assign push_packet = '{tag: x_instr.oct, data: result};
    assign pop = x_instr.vi ? x_instr.icd : '0;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (x_instr.vi && x_instr.dt == dst_reg) begin
            regs[x_instr.di] <= result;
        end
    end

    // Sticky until reset.
    always_ff @(posedge clock) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (x_instr.vi && x_instr.op == op_halt) begin
            halted <= 1'b1;
        end
    end

    single_push: assert property (@(posedge clock) disable iff (rst) $onehot0(push));

endmodule

`default_nettype wire

// ==== rtl/host_port.sv ====
`default_nettype none

module host_port
    import tia_pkg::*;
(
    input wire logic clock,
    input wire logic rst,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_we,
    input wire logic [wb_addr_width-1:0] wb_adr,
    input wire logic [wb_data_width-1:0] wb_dat_w,
    input wire logic [word_width-1:0] regs [num_regs],
    input wire logic [num_preds-1:0] preds,
    input wire logic halted,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic wb_ack,
    output instr_t slots [num_slots]
);

    logic request;
    logic instr_sel;
    logic reg_sel;
    logic [wb_addr_width-1:0] instr_off;
    logic [wb_addr_width-1:0] reg_off;
    logic [slot_index_width-1:0] slot_idx;
    logic [reg_index_width-1:0] reg_idx;
    logic [wb_data_width-1:0] read_word;

    // New cycle seen, ack follows on the next edge.
    assign request = wb_cyc && wb_stb && !wb_ack;

    assign instr_off = wb_adr - wb_addr_width'(addr_instr_base);
    assign reg_off = wb_adr - wb_addr_width'(addr_reg_base);
    assign instr_sel = (wb_adr < addr_reg_base);
    assign reg_sel = (wb_adr >= addr_reg_base) && (wb_adr < addr_status);
    assign slot_idx = instr_off[slot_index_width:1];
    assign reg_idx = reg_off[reg_index_width-1:0];

    always_comb begin
        read_word = '0;
        if (instr_sel) begin
            read_word = instr_off[0] ? slots[slot_idx][2*wb_data_width-1:wb_data_width]
                                     : slots[slot_idx][wb_data_width-1:0];
        end else if (reg_sel) begin
            read_word = {{(wb_data_width - word_width){1'b0}}, regs[reg_idx]};
        end else if (wb_adr == addr_status) begin
            read_word = {23'd0, halted, 4'd0, preds};
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= request;
        end
        wb_dat_r <= read_word;
    end

    // Odd address holds the upper half of a slot.
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < num_slots; i++) begin
                slots[i] <= '0;
            end
        end else if (request && wb_we && instr_sel) begin
            if (instr_off[0]) begin
                slots[slot_idx][2*wb_data_width-1:wb_data_width] <= wb_dat_w;
            end else begin
                slots[slot_idx][wb_data_width-1:0] <= wb_dat_w;
            end
        end
    end

    ack_in_cycle: assert property (@(posedge clock) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

// ==== rtl/integer_alu.sv ====
`default_nettype none

module integer_alu
    import tia_pkg::*;
(
    input wire op_t op,
    input wire logic [word_width-1:0] a,
    input wire logic [word_width-1:0] b,
    output logic [word_width-1:0] result
);

    // Sums and differences wrap at the word width.
    always_comb begin
        case (op)
            op_mov: result = a;
            op_add: result = a + b;
            op_sub: result = a - b;
            op_and: result = a & b;
            op_or: result = a | b;
            op_xor: result = a ^ b;
            op_eq: result = word_width'(a == b);
            // Unsigned compare.
            op_lt: result = word_width'(a < b);
            op_nop: result = '0;
            op_halt: result = '0;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/tia_core.sv ====
`default_nettype none

module tia_core
    import tia_pkg::*;
(
    input wire logic clock,
    input wire logic rst,
    input wire logic execute,
    output logic halted,
    output logic channels_quiescent,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_we,
    input wire logic [wb_addr_width-1:0] wb_adr,
    input wire logic [wb_data_width-1:0] wb_dat_w,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic wb_ack,
    input wire logic [num_in-1:0] in_valid,
    output logic [num_in-1:0] in_ready,
    input wire logic [tag_width-1:0] in_tag [num_in],
    input wire logic [word_width-1:0] in_data [num_in],
    output logic [num_out-1:0] out_valid,
    input wire logic [num_out-1:0] out_ready,
    output logic [tag_width-1:0] out_tag [num_out],
    output logic [word_width-1:0] out_data [num_out]
);

    instr_t slots [num_slots];
    instr_t fire_instr;
    instr_t x_instr;
    logic fire;
    logic [num_preds-1:0] preds;
    logic pred_we;
    logic [reg_index_width-1:0] pred_idx;
    logic pred_val;
    logic [word_width-1:0] regs [num_regs];
    packet_t in_heads [num_in];
    logic [tag_width-1:0] in_head_tags [num_in];
    logic [num_in-1:0] in_empty;
    logic [num_in-1:0] in_full;
    logic [num_in-1:0] pop;
    packet_t out_heads [num_out];
    logic [num_out-1:0] out_empty;
    logic [num_out-1:0] out_full;
    logic [num_out-1:0] push;
    packet_t push_packet;

    for (genvar c = 0; c < num_in; c++) begin : g_in
        channel_fifo u_fifo (
            .clock(clock), .rst(rst),
            .push(in_valid[c] && !in_full[c]),
            .push_packet('{tag: in_tag[c], data: in_data[c]}),
            .pop(pop[c]), .head(in_heads[c]), .empty(in_empty[c]), .full(in_full[c])
        );
        assign in_ready[c] = !in_full[c];
        assign in_head_tags[c] = in_heads[c].tag;
    end

    for (genvar c = 0; c < num_out; c++) begin : g_out
        channel_fifo u_fifo (
            .clock(clock), .rst(rst), .push(push[c]), .push_packet(push_packet),
            .pop(out_ready[c] && !out_empty[c]),
            .head(out_heads[c]), .empty(out_empty[c]), .full(out_full[c])
        );
        assign out_valid[c] = !out_empty[c];
        assign out_tag[c] = out_heads[c].tag;
        assign out_data[c] = out_heads[c].data;
    end

    host_port u_host (
        .clock(clock), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .regs(regs), .preds(preds), .halted(halted),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .slots(slots)
    );

    trigger_unit u_trigger (
        .clock(clock), .rst(rst), .execute(execute), .halted(halted), .slots(slots),
        .in_empty(in_empty), .in_head_tags(in_head_tags), .out_full(out_full),
        .x_instr(x_instr), .pred_we(pred_we), .pred_idx(pred_idx), .pred_val(pred_val),
        .fire(fire), .fire_instr(fire_instr), .preds(preds)
    );

    execute_stage u_execute (
        .clock(clock), .rst(rst), .fire(fire), .fire_instr(fire_instr), .in_heads(in_heads),
        .x_instr(x_instr), .pop(pop), .push(push), .push_packet(push_packet),
        .pred_we(pred_we), .pred_idx(pred_idx), .pred_val(pred_val), .regs(regs),
        .halted(halted)
    );

    assign channels_quiescent = (&in_empty) && (&out_empty);

endmodule

`default_nettype wire

// ==== rtl/tia_pkg.sv ====
`default_nettype none

package tia_pkg;

    localparam int word_width = 16;
    localparam int tag_width = 2;
    localparam int num_in = 2;
    localparam int num_out = 2;
    localparam int num_regs = 4;
    localparam int num_preds = 4;
    localparam int num_slots = 8;
    localparam int slot_index_width = 3;
    localparam int reg_index_width = 2;
    localparam int chan_depth = 4;

    // Host bus and its address map.
    localparam int wb_addr_width = 5;
    localparam int wb_data_width = 32;
    localparam int addr_instr_base = 0;
    localparam int addr_reg_base = 16;
    localparam int addr_status = 20;

    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_mov = 4'd1,
        op_add = 4'd2,
        op_sub = 4'd3,
        op_and = 4'd4,
        op_or = 4'd5,
        op_xor = 4'd6,
        op_eq = 4'd7,
        op_lt = 4'd8,
        op_halt = 4'd9
    } op_t;

    typedef enum logic [1:0] {
        src_imm = 2'd0,
        src_reg = 2'd1,
        src_chan = 2'd2
    } src_t;

    typedef enum logic [1:0] {
        dst_none = 2'd0,
        dst_reg = 2'd1,
        dst_out = 2'd2,
        dst_pred = 2'd3
    } dst_t;

    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic [word_width-1:0] data;
    } packet_t;

    // 59 bits of fields, zero padded to 64.
    typedef struct packed {
        logic vi;
        logic [num_preds-1:0] ptm;
        logic [num_preds-1:0] pfm;
        logic [num_in-1:0] icr;
        logic [num_in-1:0] ictm;
        logic [tag_width-1:0] ict;
        op_t op;
        src_t st0;
        logic [reg_index_width-1:0] si0;
        src_t st1;
        logic [reg_index_width-1:0] si1;
        dst_t dt;
        logic [reg_index_width-1:0] di;
        logic [tag_width-1:0] oct;
        logic [num_in-1:0] icd;
        logic [num_preds-1:0] pus;
        logic [num_preds-1:0] puc;
        logic [word_width-1:0] imm;
        logic [4:0] pad;
    } instr_t;

endpackage

`default_nettype wire

// ==== rtl/trigger_unit.sv ====
`default_nettype none

module trigger_unit
    import tia_pkg::*;
(
    input wire logic clock,
    input wire logic rst,
    input wire logic execute,
    input wire logic halted,
    input wire instr_t slots [num_slots],
    input wire logic [num_in-1:0] in_empty,
    input wire logic [tag_width-1:0] in_head_tags [num_in],
    input wire logic [num_out-1:0] out_full,
    input wire instr_t x_instr,
    input wire logic pred_we,
    input wire logic [reg_index_width-1:0] pred_idx,
    input wire logic pred_val,
    output logic fire,
    output instr_t fire_instr,
    output logic [num_preds-1:0] preds
);

    logic [num_in-1:0] eff_empty;
    logic [num_out-1:0] eff_full;
    logic hazard;
    logic [num_slots-1:0] qual;
    logic [slot_index_width-1:0] sel_idx;
    logic [num_preds-1:0] preds_next;

    // Pessimistic status: in-flight dequeues empty a channel, in-flight writes fill one.
    always_comb begin
        eff_empty = in_empty | (x_instr.vi ? x_instr.icd : '0);
        for (int c = 0; c < num_out; c++) begin
            eff_full[c] = out_full[c] || (x_instr.vi && x_instr.dt == dst_out && x_instr.di == c);
        end
    end

    // Halt in execute also stalls, so nothing runs behind it.
    assign hazard = x_instr.vi && (x_instr.dt == dst_pred || x_instr.op == op_halt);

    always_comb begin
        for (int s = 0; s < num_slots; s++) begin
            qual[s] = slots[s].vi
                && ((preds & slots[s].ptm) == slots[s].ptm)
                && ((preds & slots[s].pfm) == '0)
                && (((slots[s].icr | slots[s].ictm) & eff_empty) == '0);
            for (int c = 0; c < num_in; c++) begin
                if (slots[s].ictm[c] && in_head_tags[c] != slots[s].ict) begin
                    qual[s] = 1'b0;
                end
            end
            for (int c = 0; c < num_out; c++) begin
                if (slots[s].dt == dst_out && slots[s].di == c && eff_full[c]) begin
                    qual[s] = 1'b0;
                end
            end
        end
    end

    // Lowest index wins.
    always_comb begin
        sel_idx = '0;
        for (int s = num_slots - 1; s >= 0; s--) begin
            if (qual[s]) begin
                sel_idx = slot_index_width'(s);
            end
        end
    end

    assign fire = execute && !halted && !hazard && (qual != '0);
    assign fire_instr = fire ? slots[sel_idx] : '0;

    always_comb begin
        preds_next = preds;
        if (pred_we) begin
            preds_next[pred_idx] = pred_val;
        end
        if (fire) begin
            preds_next = (preds_next & ~fire_instr.puc) | fire_instr.pus;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            preds <= '0;
        end else begin
            preds <= preds_next;
        end
    end

    fire_valid_slot: assert property (@(posedge clock) disable iff (rst)
        fire |-> slots[sel_idx].vi);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_top -f project.f && \
./obj_dir/Vtb_top | tee /dev/stderr | grep "Regression passed" > /dev/null || {
    echo "simulation did not report a pass"
    exit 1
}

// ==== sim/core_checker.sv ====
`default_nettype none

module core_checker
    import tia_pkg::*;
(
    input wire logic clock,
    input wire logic rst,
    input wire logic [3:0] test_id,
    input wire logic test_done,
    input wire logic run_done,
    input wire logic wb_we,
    input wire logic [wb_addr_width-1:0] wb_adr,
    input wire logic [wb_data_width-1:0] wb_dat_w,
    input wire logic [wb_data_width-1:0] wb_dat_r,
    input wire logic wb_ack,
    input wire logic [num_in-1:0] in_valid,
    input wire logic [num_in-1:0] in_ready,
    input wire logic [tag_width-1:0] in_tag [num_in],
    input wire logic [word_width-1:0] in_data [num_in],
    input wire logic [num_out-1:0] out_valid,
    input wire logic [num_out-1:0] out_ready,
    input wire logic [tag_width-1:0] out_tag [num_out],
    input wire logic [word_width-1:0] out_data [num_out],
    input wire logic halted,
    input wire logic channels_quiescent,
    output int tests_failed
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [63:0] prog [num_slots];
    logic [word_width-1:0] exp_regs [num_regs];
    logic exp_halted;
    logic [num_preds-1:0] exp_preds;
    packet_t exp_out0 [$];
    packet_t exp_out1 [$];
    int errors = 0;
    int tests_run = 0;
    int failed = 0;

    assign tests_failed = failed;

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1: return "host_store";
            4'd2: return "pass_through";
            4'd3: return "tag_dispatch";
            4'd4: return "pred_sequence";
            4'd5: return "compare_halt";
            default: return "unknown";
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name(test_id), what,
                     expected, actual);
            errors++;
        end
    endtask

    // Host writes build the program image and reads are compared against it.
    task automatic model_host();
        int a;
        logic [31:0] want;
        a = int'(wb_adr);
        if (wb_we) begin
            if (a < addr_reg_base && a % 2 == 1) begin
                prog[a / 2][63:32] = wb_dat_w;
            end else if (a < addr_reg_base) begin
                prog[a / 2][31:0] = wb_dat_w;
            end
        end else if (a < addr_reg_base) begin
            want = (a % 2 == 1) ? prog[a / 2][63:32] : prog[a / 2][31:0];
            check($sformatf("slot word %0d", a), want, wb_dat_r);
        end else if (a < addr_status) begin
            check($sformatf("register %0d", a - addr_reg_base),
                  {16'd0, exp_regs[a - addr_reg_base]}, wb_dat_r);
        end else begin
            check("status", {23'd0, exp_halted, 4'd0, exp_preds}, wb_dat_r);
        end
    endtask

    // Per-test program behavior for one accepted input packet.
    task automatic model_input(input int c, input packet_t p);
        instr_t s0;
        instr_t s1;
        instr_t s2;
        packet_t e;
        s0 = instr_t'(prog[0]);
        s1 = instr_t'(prog[1]);
        s2 = instr_t'(prog[2]);
        case (test_id)
            4'd2: begin
                e.tag = s0.oct;
                e.data = p.data + s0.imm;
                exp_out0.push_back(e);
            end
            4'd3: begin
                if (p.tag == s0.ict) begin
                    e.tag = s0.oct;
                    e.data = p.data ^ s0.imm;
                    exp_out0.push_back(e);
                end else begin
                    e.tag = s1.oct;
                    e.data = p.data ^ s1.imm;
                    exp_out1.push_back(e);
                end
            end
            4'd4: begin
                if (c == 1) begin
                    exp_regs[1] = exp_regs[1] + p.data;
                end else begin
                    exp_regs[1] = exp_regs[1] - p.data;
                end
            end
            4'd5: begin
                if (p.data < s1.imm) begin
                    exp_halted = 1'b1;
                    exp_preds = s1.pus | (num_preds'(1) << s1.di);
                end else begin
                    e.tag = s2.oct;
                    e.data = p.data;
                    exp_out0.push_back(e);
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic model_output(input int c, input packet_t p);
        packet_t e;
        if (c == 0 && exp_out0.size() > 0) begin
            e = exp_out0.pop_front();
        end else if (c == 1 && exp_out1.size() > 0) begin
            e = exp_out1.pop_front();
        end else begin
            $display("ERROR %s: output %0d sent a packet that was not expected",
                     test_name(test_id), c);
            errors++;
            return;
        end
        check($sformatf("output %0d packet", c), 32'(e), 32'(p));
    endtask

    always @(negedge clock) begin
        if (rst) begin
            for (int s = 0; s < num_slots; s++) begin
                prog[s] = '0;
            end
            for (int r = 0; r < num_regs; r++) begin
                exp_regs[r] = '0;
            end
            exp_halted = 1'b0;
            exp_preds = '0;
            exp_out0.delete();
            exp_out1.delete();
        end else begin
            if (wb_ack) begin
                model_host();
            end
            for (int c = 0; c < num_in; c++) begin
                if (in_valid[c] && in_ready[c]) begin
                    model_input(c, {in_tag[c], in_data[c]});
                end
            end
            for (int c = 0; c < num_out; c++) begin
                if (out_valid[c] && out_ready[c]) begin
                    model_output(c, {out_tag[c], out_data[c]});
                end
            end
        end
        if (test_done) begin
            check("halted", {31'd0, exp_halted}, {31'd0, halted});
            check("channels_quiescent", 32'd1, {31'd0, channels_quiescent});
            if (exp_out0.size() + exp_out1.size() != 0) begin
                $display("ERROR %s: %0d expected output packets never appeared",
                         test_name(test_id), exp_out0.size() + exp_out1.size());
                errors++;
            end
            tests_run++;
            if (errors == 0) begin
                $display("test %0d %s: ok", test_id, test_name(test_id));
            end else begin
                failed++;
                $display("test %0d %s: FAILED with %0d errors", test_id, test_name(test_id),
                         errors);
            end
            errors = 0;
        end
        if (run_done) begin
            $display("summary: %0d tests run, %0d ok, %0d failed", tests_run,
                     tests_run - failed, failed);
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
`default_nettype none

module tb_top
    import tia_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int stream_limit = 4000;
    localparam int wait_limit = 2000;
    localparam int max_packets = 64;

    logic clock;
    logic rst;
    logic execute;
    logic halted;
    logic channels_quiescent;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic wb_ack;
    logic [num_in-1:0] in_valid;
    logic [num_in-1:0] in_ready;
    logic [tag_width-1:0] in_tag [num_in];
    logic [word_width-1:0] in_data [num_in];
    logic [num_out-1:0] out_valid;
    logic [num_out-1:0] out_ready;
    logic [tag_width-1:0] out_tag [num_out];
    logic [word_width-1:0] out_data [num_out];
    logic [3:0] test_id;
    logic test_done;
    logic run_done;
    int tests_failed;
    logic hung;
    logic [tag_width-1:0] stim_tag [num_in][max_packets];
    logic [word_width-1:0] stim_data [num_in][max_packets];

    tia_core u_dut (.*);

    core_checker u_check (.*);

    always #4 clock = ~clock;

    // A stalled wait ends the run at the next edge.
    always @(posedge clock) begin
        if (hung) begin
            $display("Regression failed");
            $finish;
        end
    end

    task automatic wb_access(input logic we, input int adr, input logic [31:0] dat);
        int t;
        @(posedge clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= wb_addr_width'(adr);
        wb_dat_w <= dat;
        t = 0;
        @(negedge clock);
        while (!wb_ack && t < 16) begin
            @(negedge clock);
            t++;
        end
        if (!wb_ack) begin
            $display("timeout: no Wishbone ack for address %0d", adr);
            hung = 1'b1;
        end
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic load_slot(input int s, input instr_t ins);
        wb_access(1'b1, addr_instr_base + 2 * s, ins[31:0]);
        wb_access(1'b1, addr_instr_base + 2 * s + 1, ins[63:32]);
    endtask

    // Valid slot that needs and dequeues one input channel.
    function automatic instr_t make_instr(input op_t op, input src_t st0, input int si0,
            input src_t st1, input int si1, input dst_t dt, input int di, input int chan);
        instr_t ins;
        ins = '0;
        ins.vi = 1'b1;
        ins.op = op;
        ins.st0 = st0;
        ins.si0 = reg_index_width'(si0);
        ins.st1 = st1;
        ins.si1 = reg_index_width'(si1);
        ins.dt = dt;
        ins.di = reg_index_width'(di);
        ins.icr = num_in'(1 << chan);
        ins.icd = ins.icr;
        ins.oct = tag_width'($urandom);
        ins.imm = word_width'($urandom);
        return ins;
    endfunction

    task automatic start_test(input int id);
        @(posedge clock);
        test_id <= 4'(id);
        rst <= 1'b1;
        execute <= 1'b0;
        in_valid <= '0;
        out_ready <= '0;
        repeat (8) @(posedge clock);
        rst <= 1'b0;
    endtask

    task automatic finish_test();
        @(posedge clock);
        execute <= 1'b0;
        test_done <= 1'b1;
        @(posedge clock);
        test_done <= 1'b0;
    endtask

    // Feeds the stimulus arrays with random valid gaps and random out_ready.
    task automatic run_stream(input int n0, input int n1);
        int total [num_in];
        int sent [num_in];
        logic [num_in-1:0] held;
        int cycles;
        total[0] = n0;
        total[1] = n1;
        sent[0] = 0;
        sent[1] = 0;
        held = '0;
        cycles = 0;
        @(posedge clock);
        execute <= 1'b1;
        while ((sent[0] < n0 || sent[1] < n1) && cycles < stream_limit) begin
            @(negedge clock);
            for (int c = 0; c < num_in; c++) begin
                held[c] = in_valid[c] && !in_ready[c];
                if (in_valid[c] && in_ready[c]) begin
                    sent[c]++;
                end
            end
            @(posedge clock);
            for (int c = 0; c < num_in; c++) begin
                if (!held[c]) begin
                    if (sent[c] < total[c] && $urandom % 3 != 0) begin
                        in_valid[c] <= 1'b1;
                        in_tag[c] <= stim_tag[c][sent[c]];
                        in_data[c] <= stim_data[c][sent[c]];
                    end else begin
                        in_valid[c] <= 1'b0;
                    end
                end
            end
            out_ready <= num_out'($urandom);
            cycles++;
        end
        if (sent[0] < n0 || sent[1] < n1) begin
            $display("timeout: input channels stopped accepting packets");
            hung = 1'b1;
        end
    endtask

    task automatic wait_until(input logic for_halt);
        int t;
        t = 0;
        @(negedge clock);
        while (!(for_halt ? halted : channels_quiescent) && t < wait_limit) begin
            @(posedge clock);
            out_ready <= num_out'($urandom);
            @(negedge clock);
            t++;
        end
        if (!(for_halt ? halted : channels_quiescent)) begin
            $display("timeout: %s never went high", for_halt ? "halted" : "channels_quiescent");
            hung = 1'b1;
        end
    endtask

    initial begin
        instr_t ins;
        void'($urandom(87));
        clock = 1'b0;
        rst = 1'b1;
        execute = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        in_valid = '0;
        out_ready = '0;
        test_id = '0;
        test_done = 1'b0;
        run_done = 1'b0;
        hung = 1'b0;
        for (int c = 0; c < num_in; c++) begin
            in_tag[c] = '0;
            in_data[c] = '0;
        end

        start_test(1);
        for (int a = 0; a < 2 * num_slots; a++) begin
            wb_access(1'b1, a, $urandom);
        end
        wb_access(1'b1, addr_reg_base, $urandom);
        for (int a = 0; a <= addr_status; a++) begin
            wb_access(1'b0, a, 32'd0);
        end
        finish_test();

        start_test(2);
        load_slot(0, make_instr(op_add, src_chan, 0, src_imm, 0, dst_out, 0, 0));
        for (int i = 0; i < 40; i++) begin
            stim_tag[0][i] = tag_width'($urandom);
            stim_data[0][i] = word_width'($urandom);
        end
        run_stream(40, 0);
        wait_until(1'b0);
        finish_test();

        // Tag 0 goes to output 0, tag 1 to output 1.
        start_test(3);
        for (int s = 0; s < 2; s++) begin
            ins = make_instr(op_xor, src_chan, 0, src_imm, 0, dst_out, s, 0);
            ins.ictm = 2'b01;
            ins.ict = tag_width'(s);
            load_slot(s, ins);
        end
        for (int i = 0; i < 48; i++) begin
            stim_tag[0][i] = tag_width'($urandom % 2);
            stim_data[0][i] = word_width'($urandom);
        end
        run_stream(48, 0);
        wait_until(1'b0);
        finish_test();

        start_test(4);
        ins = make_instr(op_add, src_reg, 1, src_chan, 1, dst_reg, 1, 1);
        ins.pfm = 4'b0001;
        ins.pus = 4'b0001;
        load_slot(0, ins);
        ins = make_instr(op_sub, src_reg, 1, src_chan, 0, dst_reg, 1, 0);
        ins.ptm = 4'b0001;
        ins.puc = 4'b0001;
        load_slot(1, ins);
        for (int i = 0; i < 24; i++) begin
            stim_data[0][i] = word_width'($urandom);
            stim_data[1][i] = word_width'($urandom);
            stim_tag[0][i] = tag_width'($urandom);
            stim_tag[1][i] = tag_width'($urandom);
        end
        run_stream(24, 24);
        wait_until(1'b0);
        wb_access(1'b0, addr_reg_base + 1, 32'd0);
        finish_test();

        // p3 marks a compared head, p2 is the compare result.
        start_test(5);
        ins = make_instr(op_halt, src_imm, 0, src_imm, 0, dst_none, 0, 0);
        ins.ptm = 4'b0100;
        load_slot(0, ins);
        ins = make_instr(op_lt, src_chan, 0, src_imm, 0, dst_pred, 2, 0);
        ins.imm = 16'h4000;
        ins.icd = '0;
        ins.pfm = 4'b1000;
        ins.pus = 4'b1000;
        load_slot(1, ins);
        ins = make_instr(op_mov, src_chan, 0, src_imm, 0, dst_out, 0, 0);
        ins.ptm = 4'b1000;
        ins.pfm = 4'b0100;
        ins.puc = 4'b1000;
        load_slot(2, ins);
        for (int i = 0; i < 31; i++) begin
            stim_tag[0][i] = tag_width'($urandom);
            stim_data[0][i] = word_width'($urandom) | 16'h4000;
        end
        stim_data[0][30] = word_width'($urandom) & 16'h3fff;
        run_stream(31, 0);
        wait_until(1'b1);
        wb_access(1'b0, addr_status, 32'd0);
        wait_until(1'b0);
        finish_test();

        @(posedge clock);
        run_done <= 1'b1;
        @(posedge clock);
        run_done <= 1'b0;
        @(negedge clock);
        if (tests_failed == 0 && !hung) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
